// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_pcm_to_i2s
FILELIST = sources.f
OBJDIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /^Simulation passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

// File: hw/frame_fifo.sv
`timescale 1ns/1ns

module frame_fifo (
    input logic           clk,
    input logic           reset,
    frame_fifo_if.store   port
);
    import pcm_format_pkg::*;

    frame_t                 mem [fifo_depth];   // frame storage
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    fifo_count_t            count;              // frames stored

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[wr_ptr] <= port.wr_frame;
        end
    end

    // pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (port.wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (port.rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // simultaneous read and write leave the count unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({port.wr_en, port.rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // first-word-fall-through read port
    assign port.rd_frame = mem[rd_ptr];

    assign port.empty     = (count == '0);
    assign port.full      = (count == fifo_count_t'(fifo_depth));
    assign port.half_full = (count >= fifo_count_t'(half_full_level));

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (reset)
        port.rd_en |-> !port.empty
    );

    a_no_write_full: assert property (
        @(posedge clk) disable iff (reset)
        port.wr_en |-> !port.full
    );

    // occupancy bound over the whole run
    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= fifo_count_t'(fifo_depth)
    );

endmodule

// File: hw/frame_fifo_if.sv
`timescale 1ns/1ns

interface frame_fifo_if;
    import pcm_format_pkg::*;

    logic   wr_en;       // write strobe
    frame_t wr_frame;    // frame to store
    logic   full;        // no room for another frame
    logic   rd_en;       // read strobe, pops the oldest frame
    frame_t rd_frame;    // oldest frame, valid while empty is low
    logic   empty;       // nothing stored
    logic   half_full;   // count at or above the start level

    modport writer (
        output wr_en,
        output wr_frame,
        input  full
    );

    modport reader (
        output rd_en,
        input  rd_frame,
        input  empty,
        input  half_full
    );

    modport store (
        input  wr_en,
        input  wr_frame,
        output full,
        input  rd_en,
        output rd_frame,
        output empty,
        output half_full
    );

endinterface

// File: hw/i2s_serializer.sv
`timescale 1ns/1ns

module i2s_serializer (
    input  logic          clk,
    input  logic          reset,
    input  logic          audio_en,
    frame_fifo_if.reader  fifo,
    output logic          bclk,
    output logic          lrclk,
    output logic          s_data,
    output logic          underrun
);
    import pcm_format_pkg::*;
    import i2s_timing_pkg::*;

    tx_state_t            state;
    bclk_count_t          bclk_cnt;      // clk position inside one bclk
    bit_count_t           bit_cnt;       // bclk index inside the frame
    bit_count_t           nxt_bit;
    frame_t               frame_q;       // frame being sent
    logic [slot_bits-1:0] shift_q;       // slot shifter, MSB on the line
    logic                 run_active;
    logic                 bclk_fall;
    logic                 frame_start;

    // one idle bclk, 24 data bits MSB first, then zero padding
    function automatic logic [slot_bits-1:0] slot_word(input sample_t smp);
        return {1'b0, smp, {(slot_bits - sample_w - 1){1'b0}}};
    endfunction

    assign run_active  = (state == tx_run) && audio_en;
    assign bclk_fall   = run_active && (bclk_cnt == bclk_count_t'(clks_per_bclk / 2));
    assign nxt_bit     = bit_cnt + 1'b1;
    assign frame_start = bclk_fall && (nxt_bit == '0);   // start of bclk 0

    assign fifo.rd_en = frame_start && !fifo.empty;
    assign underrun   = frame_start && fifo.empty;       // silence inserted
    assign s_data     = shift_q[slot_bits-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= tx_idle;
        end else begin
            case (state)
                tx_idle: begin
                    if (audio_en) begin
                        state <= tx_prefill;
                    end
                end
                tx_prefill: begin
                    if (!audio_en) begin
                        state <= tx_idle;
                    end else if (fifo.half_full) begin
                        state <= tx_run;
                    end
                end
                tx_run: begin
                    if (!audio_en) begin
                        state <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // Outside run the divider parks on the falling phase and the bit
    // counter on the last bclk, so the first step of a run is a frame start.
    always_ff @(posedge clk) begin
        if (reset || !run_active) begin
            bclk_cnt <= bclk_count_t'(clks_per_bclk / 2);
            bit_cnt  <= '1;
            bclk     <= 1'b0;
            lrclk    <= 1'b0;
            shift_q  <= '0;
        end else begin
            if (bclk_cnt == bclk_count_t'(clks_per_bclk - 1)) begin
                bclk_cnt <= '0;
            end else begin
                bclk_cnt <= bclk_cnt + 1'b1;
            end
            if (bclk_cnt == '0) begin
                bclk <= 1'b1;
            end
            if (bclk_fall) begin
                bclk    <= 1'b0;
                bit_cnt <= nxt_bit;
                lrclk   <= (nxt_bit >= slot_bits);   // high in the right slot
                if (frame_start) begin
                    shift_q <= slot_word(fifo.empty ? {sample_w{1'b0}}
                                                    : fifo.rd_frame[sample_w +: sample_w]);
                end else if (nxt_bit == slot_bits) begin
                    shift_q <= slot_word(frame_q[0 +: sample_w]);
                end else begin
                    shift_q <= {shift_q[slot_bits-2:0], 1'b0};
                end
            end
        end
    end

    // keeps the right half for the second slot
    always_ff @(posedge clk) begin
        if (frame_start) begin
            frame_q <= fifo.empty ? '0 : fifo.rd_frame;
        end
    end

    a_rd_only_in_run: assert property (
        @(posedge clk) disable iff (reset)
        fifo.rd_en |-> (state == tx_run)
    );

    // lrclk moves with the falling bclk, except when audio_en drops it
    a_lrclk_on_fall: assert property (
        @(posedge clk) disable iff (reset)
        ($changed(lrclk) && $past(audio_en) && !$past(reset)) |-> $fell(bclk)
    );

endmodule

// File: hw/i2s_timing_pkg.sv
package i2s_timing_pkg;

    // bclk period in system clocks
    localparam int clks_per_bclk = 8;

    // bclks per channel slot, two slots per frame
    localparam int slot_bits = 32;

    // position within one bclk period
    typedef logic [2:0] bclk_count_t;

    // bclk index within the 64-bclk frame
    typedef logic [5:0] bit_count_t;

    // transmitter states
    typedef enum logic [1:0] {
        tx_idle,      // audio disabled, outputs low
        tx_prefill,   // waiting for the buffer to reach half full
        tx_run        // clocks running, frames streaming
    } tx_state_t;

endpackage

// File: hw/pcm_format_pkg.sv
package pcm_format_pkg;

    // PCM sample width
    localparam int sample_w = 24;

    // one audio sample as it arrives from the producer side
    typedef logic [sample_w-1:0] sample_t;

    // stereo pair, left in the upper half and right in the lower half
    typedef logic [2*sample_w-1:0] frame_t;

    // frame buffer sizing
    localparam int fifo_depth      = 16;   // frames
    localparam int fifo_addr_w     = 4;    // log2 of depth
    localparam int half_full_level = 8;    // start threshold for the transmitter

    // occupancy, one bit wider than the address so full is representable
    typedef logic [fifo_addr_w:0] fifo_count_t;

endpackage

// File: hw/pcm_frame_packer.sv
`timescale 1ns/1ns

module pcm_frame_packer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    l_data_en,
    input  logic                    r_data_en,
    input  pcm_format_pkg::sample_t l_data,
    input  pcm_format_pkg::sample_t r_data,
    frame_fifo_if.writer            fifo,
    output logic                    overrun
);
    import pcm_format_pkg::*;

    sample_t left_pend;    // last left sample seen
    logic    left_valid;   // left_pend not yet paired
    frame_t  frame_q;      // frame waiting to be written
    logic    frame_pend;   // frame_q was built on the previous clock

    always_ff @(posedge clk) begin
        if (l_data_en) begin
            left_pend <= l_data;
        end
    end

    // missing left half goes out as zero
    always_ff @(posedge clk) begin
        if (r_data_en) begin
            frame_q <= {(left_valid ? left_pend : {sample_w{1'b0}}), r_data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            left_valid <= 1'b0;
            frame_pend <= 1'b0;
        end else begin
            frame_pend <= r_data_en;
            if (r_data_en) begin
                left_valid <= 1'b0;   // consumed by this frame
            end
            if (l_data_en) begin
                left_valid <= 1'b1;   // a new left waits for the next right
            end
        end
    end

    assign fifo.wr_frame = frame_q;
    assign fifo.wr_en    = frame_pend && !fifo.full;
    assign overrun       = frame_pend && fifo.full;   // frame dropped

    // full comes from the buffer, so this guards the pairing across modules
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        !(fifo.wr_en && fifo.full)
    );

endmodule

// File: hw/pcm_to_i2s_top.sv
`timescale 1ns/1ns

module pcm_to_i2s_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        audio_en,
    input  logic        l_data_en,
    input  logic        r_data_en,
    input  logic [23:0] l_data,
    input  logic [23:0] r_data,
    output logic        bclk,
    output logic        lrclk,
    output logic        s_data,
    output logic        overrun,
    output logic        underrun
);

    frame_fifo_if fifo_bus ();   // packer to buffer to serializer

    pcm_frame_packer u_packer (
        .clk       (clk),
        .reset     (reset),
        .l_data_en (l_data_en),
        .r_data_en (r_data_en),
        .l_data    (l_data),
        .r_data    (r_data),
        .fifo      (fifo_bus.writer),
        .overrun   (overrun)
    );

    frame_fifo u_fifo (
        .clk   (clk),
        .reset (reset),
        .port  (fifo_bus.store)
    );

    i2s_serializer u_serializer (
        .clk      (clk),
        .reset    (reset),
        .audio_en (audio_en),
        .fifo     (fifo_bus.reader),
        .bclk     (bclk),
        .lrclk    (lrclk),
        .s_data   (s_data),
        .underrun (underrun)
    );

endmodule

// File: sources.f
hw/pcm_format_pkg.sv
hw/i2s_timing_pkg.sv
hw/frame_fifo_if.sv
hw/pcm_frame_packer.sv
hw/frame_fifo.sv
hw/i2s_serializer.sv
hw/pcm_to_i2s_top.sv
testbench/tb_pcm_to_i2s.sv

// File: testbench/tb_pcm_to_i2s.sv
`timescale 1ns/1ns

module tb_pcm_to_i2s;

    localparam int  max_cycles  = 60000;   // ~45 frames of 512 clks needed, with margin
    localparam time restart_gap = 100;     // longer than one 80 ns bclk period

    logic        clk;
    logic        reset;
    logic        audio_en;
    logic        l_data_en;
    logic        r_data_en;
    logic [23:0] l_data;
    logic [23:0] r_data;
    logic        bclk;
    logic        lrclk;
    logic        s_data;
    logic        overrun;
    logic        underrun;

    logic [47:0] exp_q[$];              // every frame the buffer accepted, in order
    int          rd_idx = 0;            // next frame the serializer should send
    logic [47:0] cur_exp = '0;          // frame being received
    logic [23:0] slot_acc = '0;
    logic        exp_lr;
    int          bit_idx = 0;
    int          slot_pos;
    time         last_rise = 0;
    int          errors = 0;
    int          decode_errors = 0;
    int          cycles = 0;
    int          frames_done = 0;
    int          dropped = 0;           // frames turned away by the capacity rule
    int          overrun_count = 0;
    int          underrun_count = 0;
    integer      seed;

    pcm_to_i2s_top DUT (
        .clk       (clk),
        .reset     (reset),
        .audio_en  (audio_en),
        .l_data_en (l_data_en),
        .r_data_en (r_data_en),
        .l_data    (l_data),
        .r_data    (r_data),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .s_data    (s_data),
        .overrun   (overrun),
        .underrun  (underrun)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("TIMEOUT: tests did not complete within %0d cycles", max_cycles);
            $display("errors %0d, frames decoded %0d", errors + decode_errors, frames_done);
            $display("Simulation failed");
            $finish;
        end
    end

    // pulses are counted mid-cycle
    always @(negedge clk) begin
        if (!reset && overrun) begin
            overrun_count <= overrun_count + 1;
        end
        if (!reset && underrun) begin
            underrun_count <= underrun_count + 1;
        end
    end

    task automatic report_mismatch(input string name, input logic [47:0] expected,
                                   input logic [47:0] actual);
        $display("ERROR at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    // I2S receiver, samples on rising bclk
    always @(posedge bclk) begin
        if ($time - last_rise > restart_gap || bit_idx == 63) begin
            bit_idx = 0;   // a restarted bclk always begins a frame
        end else begin
            bit_idx = bit_idx + 1;
        end
        last_rise = $time;
        if (bit_idx == 0) begin
            cur_exp = '0;   // silence unless a frame is buffered
            if (rd_idx < exp_q.size()) begin
                cur_exp = exp_q[rd_idx];
                rd_idx = rd_idx + 1;
            end
        end
        exp_lr = (bit_idx >= 32);
        if (lrclk !== exp_lr) begin
            decode_errors++;
            report_mismatch("lrclk", 48'(exp_lr), 48'(lrclk));
        end
        slot_pos = bit_idx % 32;
        if (slot_pos >= 1 && slot_pos <= 24) begin
            slot_acc = {slot_acc[22:0], s_data};
        end else if (s_data !== 1'b0) begin
            decode_errors++;
            report_mismatch("s_data padding", 48'h0, 48'(s_data));
        end
        if (slot_pos == 24 && !exp_lr && slot_acc !== cur_exp[47:24]) begin
            decode_errors++;
            report_mismatch("left sample", 48'(cur_exp[47:24]), 48'(slot_acc));
        end
        if (slot_pos == 24 && exp_lr && slot_acc !== cur_exp[23:0]) begin
            decode_errors++;
            report_mismatch("right sample", 48'(cur_exp[23:0]), 48'(slot_acc));
        end
        if (bit_idx == 63) begin
            frames_done = frames_done + 1;
        end
    end

    // left strobe, then right strobe; the model drops the frame once 16 are buffered
    task automatic write_frame();
        logic [31:0] rl;
        logic [31:0] rr;
        rl = $random(seed);
        rr = $random(seed);
        @(posedge clk);
        l_data    <= rl[23:0];
        l_data_en <= 1'b1;
        @(posedge clk);
        l_data_en <= 1'b0;
        r_data    <= rr[23:0];
        r_data_en <= 1'b1;
        @(posedge clk);
        r_data_en <= 1'b0;
        if (exp_q.size() - rd_idx >= 16) begin
            dropped++;
        end else begin
            exp_q.push_back({rl[23:0], rr[23:0]});
        end
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            if ({bclk, lrclk, s_data, overrun, underrun} !== 5'b0) begin
                errors++;
                report_mismatch("{bclk,lrclk,s_data,overrun,underrun}", 48'h0,
                                48'({bclk, lrclk, s_data, overrun, underrun}));
            end
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) @(posedge clk);
    endtask

    task automatic reset_and_idle();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        expect_quiet(100);
    endtask

    task automatic prefill_gating();
        int n;
        @(posedge clk);
        audio_en <= 1'b1;
        repeat (7) write_frame();
        expect_quiet(200);   // 7 frames is below the start level
        write_frame();
        n = 0;
        while (bclk !== 1'b1 && n < 32) begin
            @(negedge clk);
            n++;
        end
        if (bclk !== 1'b1) begin
            errors++;
            $display("bclk did not start once 8 frames were buffered");
        end
    endtask

    task automatic streaming();
        int f0;
        f0 = frames_done;
        repeat (12) begin
            write_frame();
            repeat (509) @(posedge clk);   // one frame per 512 clks
        end
        if (frames_done - f0 < 11) begin
            errors++;
            report_mismatch("decoded frames", 48'(11), 48'(frames_done - f0));
        end
    endtask

    task automatic underrun_drain();
        int u0;
        while (exp_q.size() - rd_idx > 0) @(posedge clk);
        wait_frames(1);   // last buffered frame
        u0 = underrun_count;
        wait_frames(3);
        if (underrun_count - u0 != 3) begin
            errors++;
            report_mismatch("underrun pulses", 48'(3), 48'(underrun_count - u0));
        end
    endtask

    task automatic overrun_drop();
        int o0;
        int u0;
        @(posedge clk);
        audio_en <= 1'b0;
        repeat (4) @(posedge clk);
        o0 = overrun_count;
        repeat (18) write_frame();
        repeat (4) @(posedge clk);
        if (overrun_count - o0 != 2) begin
            errors++;
            report_mismatch("overrun pulses", 48'(2), 48'(overrun_count - o0));
        end
        u0 = underrun_count;
        audio_en <= 1'b1;
        wait_frames(17);   // 16 buffered frames, then silence
        if (underrun_count == u0) begin
            errors++;
            $display("no underrun once the 16 buffered frames were sent");
        end
    endtask

    task automatic disable_mid_stream();
        @(posedge clk);
        audio_en <= 1'b0;
        repeat (4) @(posedge clk);
        repeat (10) write_frame();
        audio_en <= 1'b1;
        wait_frames(1);
        while (lrclk !== 1'b0) @(negedge clk);
        while (lrclk !== 1'b1) @(negedge clk);   // right slot of the next frame
        @(posedge clk);
        audio_en <= 1'b0;
        repeat (2) @(posedge clk);
        expect_quiet(100);
        @(posedge clk);
        audio_en <= 1'b1;
        wait_frames(3);
    endtask

    initial begin
        seed      = 32'h488d44c6;
        reset     = 1'b1;
        audio_en  = 1'b0;
        l_data_en = 1'b0;
        r_data_en = 1'b0;
        l_data    = '0;
        r_data    = '0;
        reset_and_idle();
        prefill_gating();
        streaming();
        underrun_drain();
        overrun_drop();
        disable_mid_stream();
        if (overrun_count != dropped) begin
            errors++;
            report_mismatch("total overrun pulses", 48'(dropped), 48'(overrun_count));
        end
        $display("errors %0d, frames decoded %0d, overrun pulses %0d, underrun pulses %0d",
                 errors + decode_errors, frames_done, overrun_count, underrun_count);
        if (errors + decode_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
